//--- vlog.f
src/pipe_pkg.sv
src/pipe_control.sv
src/reg_file.sv
src/exec_alu.sv
src/pipe_reg.sv
src/data_mem.sv
src/pipe_top.sv
tests/pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module pipe_tb \
  -f vlog.f -o pipe_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/pipe_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation did not finish"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Result: FAIL"; exit 1; } || { echo "Result: PASS"; exit 0; }

//--- tests/pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;

  localparam int NUM_ROWS     = 30;
  localparam int RESET_CYCLES = 4;
  localparam int CLK_NS       = 20;
  localparam int WATCHDOG_NS  = (NUM_ROWS + RESET_CYCLES + 10) * CLK_NS;
  // Issue edge to the negedge where the result is visible
  localparam int WB_LATENCY   = 4;

  logic                              clk;
  logic                              rst_n;
  logic                              issue_valid;
  pipe_pkg::op_e                     issue_op;
  logic [pipe_pkg::REG_AW-1:0]       issue_rs;
  logic [pipe_pkg::REG_AW-1:0]       issue_rt;
  logic [pipe_pkg::REG_AW-1:0]       issue_rd;
  logic [pipe_pkg::IMM_W-1:0]        issue_imm;
  logic                              wb_valid;
  logic [pipe_pkg::REG_AW-1:0]       wb_rd;
  logic [pipe_pkg::XLEN-1:0]         wb_data;

  // Stimulus and expected write-back per row
  pipe_pkg::op_e                     tbl_op  [NUM_ROWS];
  logic [pipe_pkg::REG_AW-1:0]       tbl_rd  [NUM_ROWS];
  logic [pipe_pkg::REG_AW-1:0]       tbl_rs  [NUM_ROWS];
  logic [pipe_pkg::REG_AW-1:0]       tbl_rt  [NUM_ROWS];
  logic [pipe_pkg::IMM_W-1:0]        tbl_imm [NUM_ROWS];
  logic                              tbl_wr  [NUM_ROWS];
  logic [pipe_pkg::XLEN-1:0]         tbl_exp [NUM_ROWS];
  int                                row_count = 0;

  int pend_row[$];
  int pend_due[$];
  int cycle      = 0;
  int value_errs = 0;
  int seq_errs   = 0;

  pipe_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_rs    (issue_rs),
    .issue_rt    (issue_rt),
    .issue_rd    (issue_rd),
    .issue_imm   (issue_imm),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic add_row(input pipe_pkg::op_e op, input int rd, input int rs, input int rt,
                         input logic [15:0] imm, input logic wr, input logic [31:0] exp);
    tbl_op[row_count]  = op;
    tbl_rd[row_count]  = rd[4:0];
    tbl_rs[row_count]  = rs[4:0];
    tbl_rt[row_count]  = rt[4:0];
    tbl_imm[row_count] = imm;
    tbl_wr[row_count]  = wr;
    tbl_exp[row_count] = exp;
    row_count++;
  endtask

  // A NOP row leaves issue_valid low while an ADDI sits on the ports
  task automatic issue_row(input int i);
    issue_valid <= (tbl_op[i] != pipe_pkg::OP_NOP);
    issue_op    <= (tbl_op[i] == pipe_pkg::OP_NOP) ? pipe_pkg::OP_ADDI : tbl_op[i];
    issue_rd    <= tbl_rd[i];
    issue_rs    <= tbl_rs[i];
    issue_rt    <= tbl_rt[i];
    issue_imm   <= tbl_imm[i];
    if (tbl_wr[i]) begin
      pend_row.push_back(i);
      pend_due.push_back(cycle + WB_LATENCY);
    end
  endtask

  // Outputs are sampled on the falling edge, away from the driving edge
  always @(negedge clk) begin
    int row;
    int due;
    if (!rst_n) begin
      if (wb_valid !== 1'b0) begin
        $display("wb_valid went high while reset was asserted");
        seq_errs++;
      end
    end else if (wb_valid) begin
      if (pend_row.size() == 0) begin
        $display("write-back to r%0d at cycle %0d with no result pending", wb_rd, cycle);
        seq_errs++;
      end else begin
        row = pend_row.pop_front();
        due = pend_due.pop_front();
        if (due != cycle) begin
          $display("row %0d written back at cycle %0d, expected at cycle %0d", row, cycle, due);
          seq_errs++;
        end
        if (wb_rd !== tbl_rd[row]) begin
          $display("FAIL wb_rd row %0d: expected %h got %h", row, tbl_rd[row], wb_rd);
          value_errs++;
        end
        if (wb_data !== tbl_exp[row]) begin
          $display("FAIL wb_data row %0d: expected %h got %h", row, tbl_exp[row], wb_data);
          value_errs++;
        end
      end
    end else if (pend_row.size() != 0 && pend_due[0] <= cycle) begin
      $display("row %0d never showed its write-back by cycle %0d", pend_row[0], cycle);
      seq_errs++;
      row = pend_row.pop_front();
      due = pend_due.pop_front();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d results still pending", WATCHDOG_NS,
             pend_row.size());
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_n       <= 1'b0;
    issue_valid <= 1'b0;
    issue_op    <= pipe_pkg::OP_NOP;
    issue_rs    <= '0;
    issue_rt    <= '0;
    issue_rd    <= '0;
    issue_imm   <= '0;

    // op, rd, rs, rt, imm, writes, expected wb_data
    add_row(pipe_pkg::OP_ADDI,  1, 0,  0, 16'h0005, 1'b1, 32'h0000_0005);
    add_row(pipe_pkg::OP_ADDI,  2, 0,  0, 16'hFFFD, 1'b1, 32'hFFFF_FFFD);
    add_row(pipe_pkg::OP_ADD,   3, 1,  2, 16'h0000, 1'b1, 32'h0000_0002);
    add_row(pipe_pkg::OP_SUB,   4, 1,  3, 16'h0000, 1'b1, 32'h0000_0003);
    add_row(pipe_pkg::OP_AND,   5, 2,  4, 16'h0000, 1'b1, 32'h0000_0001);
    add_row(pipe_pkg::OP_OR,    6, 2,  1, 16'h0000, 1'b1, 32'hFFFF_FFFD);
    add_row(pipe_pkg::OP_XOR,   7, 1,  4, 16'h0000, 1'b1, 32'h0000_0006);
    add_row(pipe_pkg::OP_SLT,   8, 2,  1, 16'h0000, 1'b1, 32'h0000_0001);
    add_row(pipe_pkg::OP_SLT,   9, 1,  2, 16'h0000, 1'b1, 32'h0000_0000);
    // r0 write is shown at wb but must not reach the next reader
    add_row(pipe_pkg::OP_ADDI,  0, 0,  0, 16'h007F, 1'b1, 32'h0000_007F);
    add_row(pipe_pkg::OP_ADD,  10, 0,  1, 16'h0000, 1'b1, 32'h0000_0005);
    add_row(pipe_pkg::OP_ADDI, 11, 0,  0, 16'h0040, 1'b1, 32'h0000_0040);
    add_row(pipe_pkg::OP_ADDI, 12, 0,  0, 16'h1234, 1'b1, 32'h0000_1234);
    add_row(pipe_pkg::OP_SW,    0, 11, 12, 16'h0000, 1'b0, 32'h0000_0000);
    add_row(pipe_pkg::OP_LW,   13, 11, 0, 16'h0000, 1'b1, 32'h0000_1234);
    // r15 sits in both MEM and WB when the first SB reads it
    add_row(pipe_pkg::OP_ADD,  15, 13, 1, 16'h0000, 1'b1, 32'h0000_1239);
    add_row(pipe_pkg::OP_ADDI, 15, 0,  0, 16'h0011, 1'b1, 32'h0000_0011);
    add_row(pipe_pkg::OP_SB,    0, 11, 15, 16'h0004, 1'b0, 32'h0000_0000);
    add_row(pipe_pkg::OP_ADDI, 16, 0,  0, 16'h0022, 1'b1, 32'h0000_0022);
    add_row(pipe_pkg::OP_SB,    0, 11, 16, 16'h0005, 1'b0, 32'h0000_0000);
    add_row(pipe_pkg::OP_ADDI, 17, 0,  0, 16'h0033, 1'b1, 32'h0000_0033);
    add_row(pipe_pkg::OP_SB,    0, 11, 17, 16'h0006, 1'b0, 32'h0000_0000);
    add_row(pipe_pkg::OP_ADDI, 18, 0,  0, 16'h00A4, 1'b1, 32'h0000_00A4);
    add_row(pipe_pkg::OP_SB,    0, 11, 18, 16'h0007, 1'b0, 32'h0000_0000);
    add_row(pipe_pkg::OP_LW,   19, 11, 0, 16'h0004, 1'b1, 32'hA433_2211);
    add_row(pipe_pkg::OP_LB,   20, 11, 0, 16'h0007, 1'b1, 32'hFFFF_FFA4);
    add_row(pipe_pkg::OP_LB,   21, 11, 0, 16'h0005, 1'b1, 32'h0000_0022);
    // Idle slot whose ADDI to r21 must neither write back nor forward
    add_row(pipe_pkg::OP_NOP,  21, 0,  0, 16'h0100, 1'b0, 32'h0000_0000);
    add_row(pipe_pkg::OP_ADD,  22, 20, 21, 16'h0000, 1'b1, 32'hFFFF_FFC6);
    add_row(pipe_pkg::OP_SUB,  23, 0,  1, 16'h0000, 1'b1, 32'hFFFF_FFFB);

    if (row_count != NUM_ROWS) begin
      $display("stimulus table holds %0d rows instead of %0d", row_count, NUM_ROWS);
      seq_errs++;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      issue_row(i);
    end
    @(posedge clk);
    issue_valid <= 1'b0;
    issue_op    <= pipe_pkg::OP_NOP;

    // Drain, then a few idle cycles where wb_valid must stay low
    while (pend_row.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);

    $display("Errors: %0d value mismatches, %0d sequencing errors", value_errs, seq_errs);
    if (value_errs + seq_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          issue_valid,
  input  pipe_pkg::op_e                 issue_op,
  input  logic [pipe_pkg::REG_AW-1:0]   issue_rs,
  input  logic [pipe_pkg::REG_AW-1:0]   issue_rt,
  input  logic [pipe_pkg::REG_AW-1:0]   issue_rd,
  input  logic [pipe_pkg::IMM_W-1:0]    issue_imm,
  output logic                          wb_valid,
  output logic [pipe_pkg::REG_AW-1:0]   wb_rd,
  output logic [pipe_pkg::XLEN-1:0]     wb_data
);

  pipe_pkg::id_ex_t  id_ex_d;
  pipe_pkg::id_ex_t  id_ex_q;
  pipe_pkg::ex_mem_t ex_mem_d;
  pipe_pkg::ex_mem_t ex_mem_q;
  pipe_pkg::mem_wb_t mem_wb_d;
  pipe_pkg::mem_wb_t mem_wb_q;
  logic              id_ex_valid;
  logic              ex_mem_valid;
  logic              mem_wb_valid;

  pipe_pkg::op_e             dec_alu_op;
  logic                      dec_use_imm;
  logic                      dec_mem_read;
  logic                      dec_mem_write;
  logic                      dec_byte_access;
  logic                      dec_reg_write;
  pipe_pkg::fwd_e            fwd_a;
  pipe_pkg::fwd_e            fwd_b;
  logic [pipe_pkg::XLEN-1:0] rs_data;
  logic [pipe_pkg::XLEN-1:0] rt_data;
  logic [pipe_pkg::XLEN-1:0] alu_out;
  logic [pipe_pkg::XLEN-1:0] store_data;
  logic [pipe_pkg::XLEN-1:0] load_data;
  logic [pipe_pkg::XLEN-1:0] mem_result;

  pipe_control u_control (
    .issue_op       (issue_op),
    .ex_rs          (id_ex_q.rs),
    .ex_rt          (id_ex_q.rt),
    .mem_rd         (ex_mem_q.rd),
    .mem_valid      (ex_mem_valid),
    .mem_reg_write  (ex_mem_q.reg_write),
    .wb_rd          (mem_wb_q.rd),
    .wb_valid_stage (mem_wb_valid),
    .wb_reg_write   (mem_wb_q.reg_write),
    .alu_op         (dec_alu_op),
    .use_imm        (dec_use_imm),
    .mem_read       (dec_mem_read),
    .mem_write      (dec_mem_write),
    .byte_access    (dec_byte_access),
    .reg_write      (dec_reg_write),
    .fwd_a          (fwd_a),
    .fwd_b          (fwd_b)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs      (issue_rs),
    .rt      (issue_rt),
    .we      (wb_valid),
    .wd_rd   (mem_wb_q.rd),
    .wd_data (mem_wb_q.result),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  // Decode and register read, immediate sign-extended here
  assign id_ex_d = '{
    rs:          issue_rs,
    rt:          issue_rt,
    rd:          issue_rd,
    rs_data:     rs_data,
    rt_data:     rt_data,
    imm:         {{(pipe_pkg::XLEN-pipe_pkg::IMM_W){issue_imm[pipe_pkg::IMM_W-1]}}, issue_imm},
    alu_op:      dec_alu_op,
    use_imm:     dec_use_imm,
    mem_read:    dec_mem_read,
    mem_write:   dec_mem_write,
    byte_access: dec_byte_access,
    reg_write:   dec_reg_write
  };

  pipe_reg #(.payload_t(pipe_pkg::id_ex_t)) u_id_ex (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (issue_valid),
    .in_data   (id_ex_d),
    .out_valid (id_ex_valid),
    .out_data  (id_ex_q)
  );

  exec_alu u_alu (
    .alu_op     (id_ex_q.alu_op),
    .use_imm    (id_ex_q.use_imm),
    .imm        (id_ex_q.imm),
    .rs_val     (id_ex_q.rs_data),
    .rt_val     (id_ex_q.rt_data),
    .mem_fwd    (mem_result),
    .wb_fwd     (mem_wb_q.result),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .alu_out    (alu_out),
    .store_data (store_data)
  );

  assign ex_mem_d = '{
    alu_out:     alu_out,
    store_data:  store_data,
    rd:          id_ex_q.rd,
    mem_read:    id_ex_q.mem_read,
    mem_write:   id_ex_q.mem_write,
    byte_access: id_ex_q.byte_access,
    reg_write:   id_ex_q.reg_write
  };

  pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) u_ex_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (id_ex_valid),
    .in_data   (ex_mem_d),
    .out_valid (ex_mem_valid),
    .out_data  (ex_mem_q)
  );

  data_mem u_dmem (
    .clk         (clk),
    .addr        (ex_mem_q.alu_out[pipe_pkg::DMEM_AW+1:0]),
    .wdata       (ex_mem_q.store_data),
    .write_en    (ex_mem_valid && ex_mem_q.mem_write),
    .byte_access (ex_mem_q.byte_access),
    .rdata       (load_data)
  );

  // MEM-stage result, also the FROM_MEM forwarding source
  assign mem_result = ex_mem_q.mem_read ? load_data : ex_mem_q.alu_out;

  assign mem_wb_d = '{
    result:    mem_result,
    rd:        ex_mem_q.rd,
    reg_write: ex_mem_q.reg_write
  };

  pipe_reg #(.payload_t(pipe_pkg::mem_wb_t)) u_mem_wb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ex_mem_valid),
    .in_data   (mem_wb_d),
    .out_valid (mem_wb_valid),
    .out_data  (mem_wb_q)
  );

  assign wb_valid = mem_wb_valid && mem_wb_q.reg_write;
  assign wb_rd    = mem_wb_q.rd;
  assign wb_data  = mem_wb_q.result;

endmodule

`default_nettype wire

//--- src/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
  input  logic                           clk,
  input  logic [pipe_pkg::DMEM_AW+1:0]   addr,
  input  logic [pipe_pkg::XLEN-1:0]      wdata,
  input  logic                           write_en,
  input  logic                           byte_access,
  output logic [pipe_pkg::XLEN-1:0]      rdata
);

  logic [pipe_pkg::XLEN-1:0]    mem [pipe_pkg::DMEM_WORDS];
  logic [pipe_pkg::DMEM_AW-1:0] word_idx;
  logic [1:0]                   lane;
  logic [pipe_pkg::XLEN-1:0]    word;
  logic [7:0]                   lane_byte;

  assign word_idx = addr[pipe_pkg::DMEM_AW+1:2];
  assign lane     = addr[1:0];

  always_ff @(posedge clk) begin
    if (write_en) begin
      if (byte_access) begin
        mem[word_idx][lane*8 +: 8] <= wdata[7:0];
      end else begin
        mem[word_idx] <= wdata;
      end
    end
  end

  // Combinational read so a load result can be forwarded from MEM
  assign word      = mem[word_idx];
  assign lane_byte = word[lane*8 +: 8];

  always_comb begin
    if (byte_access) begin
      rdata = {{(pipe_pkg::XLEN-8){lane_byte[7]}}, lane_byte};
    end else begin
      rdata = word;
    end
  end

endmodule

`default_nettype wire

//--- src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_data <= in_data;
  end

endmodule

`default_nettype wire

//--- src/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
  input  pipe_pkg::op_e              alu_op,
  input  logic                       use_imm,
  input  logic [pipe_pkg::XLEN-1:0]  imm,
  input  logic [pipe_pkg::XLEN-1:0]  rs_val,
  input  logic [pipe_pkg::XLEN-1:0]  rt_val,
  input  logic [pipe_pkg::XLEN-1:0]  mem_fwd,
  input  logic [pipe_pkg::XLEN-1:0]  wb_fwd,
  input  pipe_pkg::fwd_e             fwd_a,
  input  pipe_pkg::fwd_e             fwd_b,
  output logic [pipe_pkg::XLEN-1:0]  alu_out,
  output logic [pipe_pkg::XLEN-1:0]  store_data
);

  logic [pipe_pkg::XLEN-1:0] op_a;
  logic [pipe_pkg::XLEN-1:0] rt_fwd;
  logic [pipe_pkg::XLEN-1:0] op_b;

  function automatic logic [pipe_pkg::XLEN-1:0] pick(
    input pipe_pkg::fwd_e            sel,
    input logic [pipe_pkg::XLEN-1:0] reg_val,
    input logic [pipe_pkg::XLEN-1:0] mem_val,
    input logic [pipe_pkg::XLEN-1:0] wb_val
  );
    case (sel)
      pipe_pkg::FROM_MEM: pick = mem_val;
      pipe_pkg::FROM_WB:  pick = wb_val;
      default:            pick = reg_val;
    endcase
  endfunction

  assign op_a   = pick(fwd_a, rs_val, mem_fwd, wb_fwd);
  assign rt_fwd = pick(fwd_b, rt_val, mem_fwd, wb_fwd);
  assign op_b   = use_imm ? imm : rt_fwd;

  // Stores take the forwarded rt, never the immediate
  assign store_data = rt_fwd;

  always_comb begin
    case (alu_op)
      pipe_pkg::OP_SUB: alu_out = op_a - op_b;
      pipe_pkg::OP_AND: alu_out = op_a & op_b;
      pipe_pkg::OP_OR:  alu_out = op_a | op_b;
      pipe_pkg::OP_XOR: alu_out = op_a ^ op_b;
      pipe_pkg::OP_SLT: begin
        alu_out = {{(pipe_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      end
      pipe_pkg::OP_ADD, pipe_pkg::OP_ADDI, pipe_pkg::OP_LW,
      pipe_pkg::OP_SW, pipe_pkg::OP_LB, pipe_pkg::OP_SB: begin
        alu_out = op_a + op_b;
      end
      default: alu_out = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [pipe_pkg::REG_AW-1:0]   rs,
  input  logic [pipe_pkg::REG_AW-1:0]   rt,
  input  logic                          we,
  input  logic [pipe_pkg::REG_AW-1:0]   wd_rd,
  input  logic [pipe_pkg::XLEN-1:0]     wd_data,
  output logic [pipe_pkg::XLEN-1:0]     rs_data,
  output logic [pipe_pkg::XLEN-1:0]     rt_data
);

  logic [pipe_pkg::XLEN-1:0] regs [2**pipe_pkg::REG_AW];
  logic                      write_live;

  // Register 0 is never written, so it stays at its reset value of zero
  assign write_live = we && (wd_rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**pipe_pkg::REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[wd_rd] <= wd_data;
    end
  end

  // Same-cycle write is visible to the reader
  assign rs_data = (write_live && (wd_rd == rs)) ? wd_data : regs[rs];
  assign rt_data = (write_live && (wd_rd == rt)) ? wd_data : regs[rt];

endmodule

`default_nettype wire

//--- src/pipe_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
  input  pipe_pkg::op_e                issue_op,
  input  logic [pipe_pkg::REG_AW-1:0]  ex_rs,
  input  logic [pipe_pkg::REG_AW-1:0]  ex_rt,
  input  logic [pipe_pkg::REG_AW-1:0]  mem_rd,
  input  logic                         mem_valid,
  input  logic                         mem_reg_write,
  input  logic [pipe_pkg::REG_AW-1:0]  wb_rd,
  input  logic                         wb_valid_stage,
  input  logic                         wb_reg_write,
  output pipe_pkg::op_e                alu_op,
  output logic                         use_imm,
  output logic                         mem_read,
  output logic                         mem_write,
  output logic                         byte_access,
  output logic                         reg_write,
  output pipe_pkg::fwd_e               fwd_a,
  output pipe_pkg::fwd_e               fwd_b
);

  logic mem_producer;
  logic wb_producer;

  // Decode of the issued opcode into the ID/EX control bits
  always_comb begin
    alu_op      = issue_op;
    use_imm     = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    byte_access = 1'b0;
    reg_write   = 1'b0;
    case (issue_op)
      pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND,
      pipe_pkg::OP_OR, pipe_pkg::OP_XOR, pipe_pkg::OP_SLT: begin
        reg_write = 1'b1;
      end
      pipe_pkg::OP_ADDI: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      pipe_pkg::OP_LW, pipe_pkg::OP_LB: begin
        use_imm     = 1'b1;
        mem_read    = 1'b1;
        reg_write   = 1'b1;
        byte_access = (issue_op == pipe_pkg::OP_LB);
      end
      pipe_pkg::OP_SW, pipe_pkg::OP_SB: begin
        use_imm     = 1'b1;
        mem_write   = 1'b1;
        byte_access = (issue_op == pipe_pkg::OP_SB);
      end
      default: begin
        alu_op = pipe_pkg::OP_NOP;
      end
    endcase
  end

  // A stage only forwards if it holds a live register write to a non-zero rd
  assign mem_producer = mem_valid && mem_reg_write && (mem_rd != '0);
  assign wb_producer  = wb_valid_stage && wb_reg_write && (wb_rd != '0);

  // MEM holds the younger result, so it is checked first
  always_comb begin
    if (mem_producer && (mem_rd == ex_rs)) begin
      fwd_a = pipe_pkg::FROM_MEM;
    end else if (wb_producer && (wb_rd == ex_rs)) begin
      fwd_a = pipe_pkg::FROM_WB;
    end else begin
      fwd_a = pipe_pkg::REGFILE;
    end

    if (mem_producer && (mem_rd == ex_rt)) begin
      fwd_b = pipe_pkg::FROM_MEM;
    end else if (wb_producer && (wb_rd == ex_rt)) begin
      fwd_b = pipe_pkg::FROM_WB;
    end else begin
      fwd_b = pipe_pkg::REGFILE;
    end
  end

endmodule

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int XLEN       = 32;
  localparam int REG_AW     = 5;
  localparam int IMM_W      = 16;
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW    = 6;

  // Pre-decoded operation codes as presented by the issuer
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLT  = 4'd6,
    OP_ADDI = 4'd7,
    OP_LW   = 4'd8,
    OP_SW   = 4'd9,
    OP_LB   = 4'd10,
    OP_SB   = 4'd11
  } op_e;

  // Source of an EX-stage operand
  typedef enum logic [1:0] {
    REGFILE  = 2'd0,
    FROM_MEM = 2'd1,
    FROM_WB  = 2'd2
  } fwd_e;

  typedef struct packed {
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs_data;
    logic [XLEN-1:0]   rt_data;
    logic [XLEN-1:0]   imm;
    op_e               alu_op;
    logic              use_imm;
    logic              mem_read;
    logic              mem_write;
    logic              byte_access;
    logic              reg_write;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0]   alu_out;
    logic [XLEN-1:0]   store_data;
    logic [REG_AW-1:0] rd;
    logic              mem_read;
    logic              mem_write;
    logic              byte_access;
    logic              reg_write;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0]   result;
    logic [REG_AW-1:0] rd;
    logic              reg_write;
  } mem_wb_t;

endpackage

`default_nettype wire
